// ==== compile.f ====
+incdir+include
logic/lcd_reg_pkg.sv
logic/ppu_pipe_pkg.sv
logic/lcd_reg_file.sv
logic/lcd_timing.sv
logic/bg_fetcher.sv
logic/pixel_out.sv
logic/ppu_top.sv
dv/ppu_clk_gen.sv
dv/ppu_tb.sv

// ==== dv/ppu_tb.sv ====
// VRAM model, register and frame stimulus, reference pixel model, checking assertions

`timescale 1ns/1ps

`include "ppu_params.svh"

module ppu_tb;

    logic                  clk;
    logic                  rst;
    logic [15:0]           addr;
    logic                  wr;
    logic                  rd;
    logic [7:0]            wr_data;
    logic [7:0]            rd_data;
    logic                  vram_rd;
    logic [15:0]           vram_addr;
    logic [7:0]            vram_data;
    ppu_pipe_pkg::shade_t  px;
    logic                  px_valid;
    logic                  irq_stat;
    logic                  irq_vblank;

    logic [7:0]            vram [0:8191];   // 8000h..9FFFh

    // register copies taken from the CPU bus at the write edge
    lcd_reg_pkg::lcdc_t    lcdc_sh = '0;
    lcd_reg_pkg::stat_en_t stat_sh = '0;
    logic [7:0]            scx_sh = 8'd0;
    logic [7:0]            scy_sh = 8'd0;
    logic [7:0]            lyc_sh = 8'd0;
    logic [7:0]            bgp_sh = 8'd0;

    // expected sequencer position for the current cycle
    int m_dot = 0;
    int m_ly = 0;
    int px_x = 0;
    int vblank_in_frame = 0;
    int stat_in_frame = 0;
    int vblank_total = 0;
    logic hblank_seen = 1'b0;

    ppu_clk_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    ppu_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .wr         (wr),
        .rd         (rd),
        .wr_data    (wr_data),
        .rd_data    (rd_data),
        .vram_rd    (vram_rd),
        .vram_addr  (vram_addr),
        .vram_data  (vram_data),
        .px         (px),
        .px_valid   (px_valid),
        .irq_stat   (irq_stat),
        .irq_vblank (irq_vblank)
    );

    // byte for the address seen at one edge is there by the next
    always @(posedge clk) begin
        if (vram_rd) begin
            vram_data <= vram[vram_addr[12:0]];
        end else begin
            vram_data <= 8'hxx;   // no read strobe, no data
        end
    end

    task automatic end_in_failure();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic value_mismatch(input string what);
        $display("mismatch at %0t ns: %s", $time, what);
        end_in_failure();
    endtask

    task automatic abort_run(input string what);
        $display("error at %0t ns: %s", $time, what);
        end_in_failure();
    endtask

    // shade of screen pixel (x, line) from the testbench VRAM copy
    function automatic ppu_pipe_pkg::shade_t expected_shade(input int line, input int x);
        int bg_x;
        int bg_y;
        int map_addr;
        int tile;
        int row_addr;
        int bit_pos;
        logic [7:0] lo;
        logic [7:0] hi;
        logic [1:0] idx;
        bg_x = (x + int'(scx_sh)) % 256;
        bg_y = (line + int'(scy_sh)) % 256;
        map_addr = lcdc_sh.map_sel ? int'(`MAP1_BASE) : int'(`MAP0_BASE);
        map_addr = map_addr + 32 * (bg_y / 8) + bg_x / 8;   // 32 entries per map row
        tile = int'(vram[map_addr - int'(`TILE_BASE_LO)]);
        if (!lcdc_sh.tile_sel && tile >= 128) begin
            tile = tile - 256;                                 // signed tile number
        end
        row_addr = lcdc_sh.tile_sel ? int'(`TILE_BASE_LO) : int'(`TILE_BASE_HI);
        row_addr = row_addr + 16 * tile + 2 * (bg_y % 8);
        lo = vram[row_addr - int'(`TILE_BASE_LO)];
        hi = vram[row_addr + 1 - int'(`TILE_BASE_LO)];
        bit_pos = 7 - bg_x % 8;                                // leftmost pixel is bit 7
        idx = {hi[bit_pos], lo[bit_pos]};
        if (!lcdc_sh.bg_on) begin
            idx = 2'd0;
        end
        return bgp_sh[2 * idx +: 2];
    endfunction

    task automatic check_stat_read(input logic [7:0] value);
        ppu_pipe_pkg::ppu_mode_e m;
        m = ppu_pipe_pkg::ppu_mode_e'(value[1:0]);
        assert (value[7] && value[6:3] == stat_sh && value[2] == (lyc_sh == 8'(m_ly)))
            else value_mismatch($sformatf("STAT upper bits %h at line %0d", value, m_ly));
        if (m_ly >= `VISIBLE_LINES) begin
            assert (m == ppu_pipe_pkg::v_blank)
                else value_mismatch($sformatf("mode %0d in vblank line %0d", m, m_ly));
        end else if (m_dot < `SCAN_DOTS) begin
            assert (m == ppu_pipe_pkg::scan)
                else value_mismatch($sformatf("mode %0d at dot %0d, expected scan", m, m_dot));
        end else if (m_dot == `SCAN_DOTS) begin
            assert (m == ppu_pipe_pkg::draw)
                else value_mismatch($sformatf("mode %0d at dot 80, expected draw", m));
        end else if (hblank_seen || m_dot == `LINE_DOTS - 1) begin
            assert (m == ppu_pipe_pkg::h_blank)
                else value_mismatch($sformatf("mode %0d after hblank, dot %0d", m, m_dot));
        end else begin
            assert (m == ppu_pipe_pkg::draw || m == ppu_pipe_pkg::h_blank)
                else value_mismatch($sformatf("mode %0d at dot %0d", m, m_dot));
        end
    endtask

    // per-cycle checks on the values before the edge, then the model steps
    always @(posedge clk) begin
        if (!rst) begin
            if (wr) begin
                case (addr)
                    lcd_reg_pkg::reg_lcdc: lcdc_sh <= lcd_reg_pkg::lcdc_t'(wr_data);
                    lcd_reg_pkg::reg_stat: stat_sh <= lcd_reg_pkg::stat_en_t'(wr_data[6:3]);
                    lcd_reg_pkg::reg_scy:  scy_sh  <= wr_data;
                    lcd_reg_pkg::reg_scx:  scx_sh  <= wr_data;
                    lcd_reg_pkg::reg_lyc:  lyc_sh  <= wr_data;
                    lcd_reg_pkg::reg_bgp:  bgp_sh  <= wr_data;
                    default: ;
                endcase
            end
            if (rd && addr == lcd_reg_pkg::reg_ly) begin
                assert (rd_data == 8'(m_ly))
                    else value_mismatch($sformatf("LY read %0d, expected %0d", rd_data, m_ly));
            end
            if (rd && addr == lcd_reg_pkg::reg_stat) begin
                check_stat_read(rd_data);
                if (rd_data[1:0] == 2'd0) hblank_seen <= 1'b1;
            end
            // tile reads only happen after the scan dots of a visible line
            if (vram_rd) begin
                assert (lcdc_sh.lcd_on && m_ly < `VISIBLE_LINES && m_dot > `SCAN_DOTS)
                    else value_mismatch($sformatf("vram_rd at line %0d dot %0d", m_ly, m_dot));
            end
            if (px_valid) begin
                assert (lcdc_sh.lcd_on && m_ly < `VISIBLE_LINES && px_x < `SCREEN_W)
                    else value_mismatch($sformatf("stray pixel, line %0d x %0d", m_ly, px_x));
                assert (px == expected_shade(m_ly, px_x))
                    else value_mismatch($sformatf("pixel line %0d x %0d is %0d, expected %0d",
                                                  m_ly, px_x, px, expected_shade(m_ly, px_x)));
                px_x <= px_x + 1;
            end
            if (irq_vblank) begin
                assert (lcdc_sh.lcd_on && m_ly == `VISIBLE_LINES && m_dot == 0)
                    else value_mismatch($sformatf("irq_vblank at line %0d dot %0d", m_ly, m_dot));
                vblank_in_frame <= vblank_in_frame + 1;
                vblank_total    <= vblank_total + 1;
            end
            if (irq_stat) begin
                assert (stat_sh.lyc_en && 8'(m_ly) == lyc_sh)
                    else value_mismatch($sformatf("irq_stat at line %0d, LYC %0d", m_ly, lyc_sh));
                stat_in_frame <= stat_in_frame + 1;
            end
            if (lcdc_sh.lcd_on && m_dot == `LINE_DOTS - 1) begin
                assert (px_x == ((m_ly < `VISIBLE_LINES) ? `SCREEN_W : 0))
                    else value_mismatch($sformatf("line %0d gave %0d pixels", m_ly, px_x));
                px_x        <= 0;
                hblank_seen <= 1'b0;
                if (m_ly == `FRAME_LINES - 1) begin
                    assert (vblank_in_frame == 1)
                        else value_mismatch($sformatf("%0d vblank pulses", vblank_in_frame));
                    assert (stat_in_frame == (stat_sh.lyc_en ? 1 : 0))
                        else value_mismatch($sformatf("%0d STAT pulses", stat_in_frame));
                    vblank_in_frame <= 0;
                    stat_in_frame   <= 0;
                end
            end
            if (!lcdc_sh.lcd_on) begin
                m_dot           <= 0;      // display held at line 0, dot 0
                m_ly            <= 0;
                px_x            <= 0;
                vblank_in_frame <= 0;
                stat_in_frame   <= 0;
                hblank_seen     <= 1'b0;
            end else if (m_dot == `LINE_DOTS - 1) begin
                m_dot <= 0;
                m_ly  <= (m_ly == `FRAME_LINES - 1) ? 0 : m_ly + 1;
            end else begin
                m_dot <= m_dot + 1;
            end
        end
    end

    a_vblank_pulse: assert property (
        @(posedge clk) disable iff (rst) irq_vblank |=> !irq_vblank
    ) else value_mismatch("irq_vblank high for two cycles");

    task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        addr    <= a;
        wr_data <= d;
        wr      <= 1'b1;
        rd      <= 1'b0;
        @(posedge clk);
        wr <= 1'b0;
    endtask

    task automatic expect_reg(input logic [15:0] a, input logic [7:0] exp);
        logic [7:0] v;
        @(posedge clk);
        addr <= a;
        rd   <= 1'b1;
        @(posedge clk);
        v = rd_data;
        rd <= 1'b0;
        assert (v == exp)
            else value_mismatch($sformatf("reg %h read %h, expected %h", a, v, exp));
    endtask

    // keep one register on the read port every cycle
    task automatic watch_reg(input logic [15:0] a);
        @(posedge clk);
        addr <= a;
        rd   <= 1'b1;
    endtask

    // n vblank interrupts, then on to line 0 so the frame end checks have run
    task automatic run_frames(input int n);
        int start_total;
        int cycles;
        start_total = vblank_total;
        cycles = 0;
        while (vblank_total < start_total + n) begin
            @(posedge clk);
            cycles++;
            if (cycles > n * `LINE_DOTS * `FRAME_LINES + `LINE_DOTS)
                abort_run("no vblank interrupt within a frame time");
        end
        cycles = 0;
        while (m_ly != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 11 * `LINE_DOTS) abort_run("frame did not wrap back to line 0");
        end
    endtask

    task automatic setup_frame(input logic [7:0] scx, input logic [7:0] scy,
                               input logic [7:0] bgp, input logic [7:0] lcdc);
        write_reg(lcd_reg_pkg::reg_scx, scx);
        write_reg(lcd_reg_pkg::reg_scy, scy);
        write_reg(lcd_reg_pkg::reg_bgp, bgp);
        write_reg(lcd_reg_pkg::reg_lcdc, lcdc);
    endtask

    initial begin
        int i;
        int unsigned seed_ret;
        int cycles;
        addr      = 16'd0;
        wr        = 1'b0;
        rd        = 1'b0;
        wr_data   = 8'd0;
        vram_data = 8'd0;
        seed_ret = $urandom(32'hbc1b_71cf);
        for (i = 0; i < 8192; i++) begin
            vram[i] = 8'($urandom());
        end
        @(posedge clk);
        cycles = 0;
        while (rst) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) abort_run("reset was never released");
        end

        // register map with the display off
        write_reg(lcd_reg_pkg::reg_scy, 8'h3C);
        expect_reg(lcd_reg_pkg::reg_scy, 8'h3C);
        write_reg(lcd_reg_pkg::reg_scx, 8'h15);
        expect_reg(lcd_reg_pkg::reg_scx, 8'h15);
        write_reg(lcd_reg_pkg::reg_lyc, 8'h5A);
        expect_reg(lcd_reg_pkg::reg_lyc, 8'h5A);
        write_reg(lcd_reg_pkg::reg_bgp, 8'hE4);
        expect_reg(lcd_reg_pkg::reg_bgp, 8'hE4);
        write_reg(lcd_reg_pkg::reg_lcdc, 8'h11);
        expect_reg(lcd_reg_pkg::reg_lcdc, 8'h11);
        expect_reg(16'hFF46, 8'hFF);
        expect_reg(lcd_reg_pkg::reg_stat, 8'h82);   // scan, no coincidence

        // fine scroll 5, unsigned tiles, map 9800h
        write_reg(lcd_reg_pkg::reg_lcdc, 8'h91);
        write_reg(lcd_reg_pkg::reg_ly, 8'h55);      // read only
        watch_reg(lcd_reg_pkg::reg_ly);
        run_frames(1);
        watch_reg(lcd_reg_pkg::reg_stat);
        run_frames(1);
        write_reg(lcd_reg_pkg::reg_lcdc, 8'h11);
        watch_reg(lcd_reg_pkg::reg_ly);
        repeat (3 * `LINE_DOTS) @(posedge clk);     // display off so nothing moves

        // signed tiles, map 9C00h, vertical wrap
        setup_frame(8'h40, 8'hC7, 8'h1B, 8'h89);
        run_frames(1);
        write_reg(lcd_reg_pkg::reg_lcdc, 8'h09);
        setup_frame(8'hFB, 8'h07, 8'hD2, 8'h99);   // map column wrap
        run_frames(1);
        write_reg(lcd_reg_pkg::reg_lcdc, 8'h19);

        // background off
        setup_frame(8'h2A, 8'h11, 8'h9E, 8'h90);
        run_frames(1);
        write_reg(lcd_reg_pkg::reg_lcdc, 8'h10);

        // LYC interrupt on line 90
        write_reg(lcd_reg_pkg::reg_stat, 8'h40);
        write_reg(lcd_reg_pkg::reg_lyc, 8'h5A);
        setup_frame(8'h15, 8'h3C, 8'hE4, 8'h91);
        watch_reg(lcd_reg_pkg::reg_ly);
        run_frames(2);
        write_reg(lcd_reg_pkg::reg_lcdc, 8'h11);
        write_reg(lcd_reg_pkg::reg_stat, 8'h00);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== dv/ppu_clk_gen.sv ====
// testbench clock source, 10 ns period, and a two-cycle reset

`timescale 1ns/1ps

module ppu_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;  // released after the second edge
    end

endmodule

// ==== logic/ppu_top.sv ====
// ppu_top: register block, sequencer, background fetcher and pixel output

`timescale 1ns/1ps

module ppu_top (
    input  logic                 clk,
    input  logic                 rst,
    // cpu register port
    input  logic [15:0]          addr,
    input  logic                 wr,
    input  logic                 rd,
    input  logic [7:0]           wr_data,
    output logic [7:0]           rd_data,
    // vram read port
    output logic                 vram_rd,
    output logic [15:0]          vram_addr,
    input  logic [7:0]           vram_data,
    // pixel stream
    output ppu_pipe_pkg::shade_t px,
    output logic                 px_valid,
    // interrupts
    output logic                 irq_stat,
    output logic                 irq_vblank
);

    lcd_reg_pkg::lcdc_t      lcdc;
    lcd_reg_pkg::stat_en_t   stat_en;
    logic [7:0]              scy;
    logic [7:0]              scx;
    logic [7:0]              lyc;
    logic [7:0]              bgp;
    ppu_pipe_pkg::ppu_mode_e mode;
    logic [7:0]              ly;
    logic                    coincidence;
    logic                    line_start;
    logic [7:0]              row_lo;
    logic [7:0]              row_hi;
    logic                    row_full;
    logic                    row_take;
    logic                    px_done_line;

    lcd_reg_file u_regs (
        .clk         (clk),
        .rst         (rst),
        .addr        (addr),
        .wr          (wr),
        .rd          (rd),
        .wr_data     (wr_data),
        .mode        (mode),
        .ly          (ly),
        .coincidence (coincidence),
        .rd_data     (rd_data),
        .lcdc        (lcdc),
        .scy         (scy),
        .scx         (scx),
        .lyc         (lyc),
        .bgp         (bgp),
        .stat_en     (stat_en),
        .irq_stat    (irq_stat)
    );

    lcd_timing u_timing (
        .clk          (clk),
        .rst          (rst),
        .lcd_on       (lcdc.lcd_on),
        .lyc          (lyc),
        .px_done_line (px_done_line),
        .mode         (mode),
        .ly           (ly),
        .coincidence  (coincidence),
        .line_start   (line_start),
        .irq_vblank   (irq_vblank)
    );

    bg_fetcher u_fetch (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .line_start (line_start),
        .ly         (ly),
        .scx        (scx),
        .scy        (scy),
        .map_sel    (lcdc.map_sel),
        .tile_sel   (lcdc.tile_sel),
        .bg_on      (lcdc.bg_on),
        .vram_data  (vram_data),
        .row_take   (row_take),
        .vram_rd    (vram_rd),
        .vram_addr  (vram_addr),
        .row_lo     (row_lo),
        .row_hi     (row_hi),
        .row_full   (row_full)
    );

    pixel_out u_pix (
        .clk          (clk),
        .rst          (rst),
        .mode         (mode),
        .line_start   (line_start),
        .scx          (scx),
        .bgp          (bgp),
        .row_lo       (row_lo),
        .row_hi       (row_hi),
        .row_full     (row_full),
        .row_take     (row_take),
        .px           (px),
        .px_valid     (px_valid),
        .px_done_line (px_done_line)
    );

endmodule

// ==== logic/pixel_out.sv ====
// pixel_out: tile row shift planes, fine scroll discard, palette lookup, pixel strobe

`timescale 1ns/1ps

`include "ppu_params.svh"

module pixel_out (
    input  logic                    clk,
    input  logic                    rst,
    input  ppu_pipe_pkg::ppu_mode_e mode,
    input  logic                    line_start,
    input  logic [7:0]              scx,
    input  logic [7:0]              bgp,
    input  logic [7:0]              row_lo,
    input  logic [7:0]              row_hi,
    input  logic                    row_full,
    output logic                    row_take,
    output ppu_pipe_pkg::shade_t    px,
    output logic                    px_valid,
    output logic                    px_done_line
);

    logic [7:0] plane_lo;
    logic [7:0] plane_hi;
    logic [3:0] left;       // pixels still in the planes
    logic [2:0] discard;
    logic [7:0] px_count;
    logic [1:0] color;
    logic       active;

    assign active       = (mode == ppu_pipe_pkg::draw) && (px_count != 8'(`SCREEN_W));
    assign row_take     = active && row_full && (left == 4'd0);
    assign px_done_line = (mode == ppu_pipe_pkg::draw) && (px_count == 8'(`SCREEN_W));
    assign color        = {plane_hi[7], plane_lo[7]};

    always_ff @(posedge clk) begin
        if (rst || mode != ppu_pipe_pkg::draw) begin
            left     <= 4'd0;
            discard  <= 3'd0;
            px_count <= 8'd0;
            px_valid <= 1'b0;
        end else begin
            px_valid <= 1'b0;
            if (line_start) begin
                discard <= scx[2:0];
            end
            if (row_take) begin
                plane_lo <= row_lo;
                plane_hi <= row_hi;
                left     <= 4'd8;
            end else if (active && left != 4'd0) begin
                plane_lo <= {plane_lo[6:0], 1'b0};
                plane_hi <= {plane_hi[6:0], 1'b0};
                left     <= left - 4'd1;
                if (discard != 3'd0) begin
                    discard <= discard - 3'd1;  // scrolled off the left edge
                end else begin
                    px       <= bgp[{color, 1'b0} +: 2];
                    px_valid <= 1'b1;
                    px_count <= px_count + 8'd1;
                end
            end
        end
    end

    // the strobe must stay inside the sequencer's draw window
    a_px_in_draw: assert property (
        @(posedge clk) disable iff (rst) px_valid |-> mode == ppu_pipe_pkg::draw
    );

endmodule

// ==== logic/bg_fetcher.sv ====
// bg_fetcher: background map and tile row reads from VRAM, one tile at a time

`timescale 1ns/1ps

`include "ppu_params.svh"

module bg_fetcher (
    input  logic                    clk,
    input  logic                    rst,
    input  ppu_pipe_pkg::ppu_mode_e mode,
    input  logic                    line_start,
    input  logic [7:0]              ly,
    input  logic [7:0]              scx,
    input  logic [7:0]              scy,
    input  logic                    map_sel,
    input  logic                    tile_sel,
    input  logic                    bg_on,
    input  logic [7:0]              vram_data,
    input  logic                    row_take,
    output logic                    vram_rd,
    output logic [15:0]             vram_addr,
    output logic [7:0]              row_lo,
    output logic [7:0]              row_hi,
    output logic                    row_full
);

    // one tile beyond the screen width covers the fine scroll
    localparam logic [4:0] LINE_TILES = 5'd21;

    ppu_pipe_pkg::fetch_state_e state;

    logic        half;      // second cycle of a read
    logic [4:0]  col;       // tiles fetched this line
    logic [4:0]  next_col;
    logic [7:0]  bg_y;
    logic [4:0]  map_x;
    logic [15:0] map_base;
    logic [15:0] map_addr;
    logic [15:0] tile_base;
    logic [15:0] tile_off;
    logic [15:0] tile_addr;

    assign bg_y     = ly + scy;                      // wraps at 256
    assign next_col = line_start ? 5'd0 : col;
    assign map_x    = next_col + scx[7:3];           // wraps at 32 tiles
    assign map_base = map_sel ? `MAP1_BASE : `MAP0_BASE;
    assign map_addr = map_base + {6'd0, bg_y[7:3], map_x};

    // tile number is the byte just read from the map
    always_comb begin
        if (tile_sel) begin
            tile_base = `TILE_BASE_LO;
            tile_off  = {4'd0, vram_data, 4'd0};
        end else begin
            tile_base = `TILE_BASE_HI;
            tile_off  = {{4{vram_data[7]}}, vram_data, 4'd0};  // signed index
        end
    end

    assign tile_addr = tile_base + tile_off + {12'd0, bg_y[2:0], 1'b0};

    // each address is held two cycles, data sampled on the second edge
    always_ff @(posedge clk) begin
        if (rst || mode != ppu_pipe_pkg::draw) begin
            state    <= ppu_pipe_pkg::idle;
            half     <= 1'b0;
            col      <= 5'd0;
            vram_rd  <= 1'b0;
            row_full <= 1'b0;
        end else if (line_start) begin
            state     <= ppu_pipe_pkg::map_rd;
            half      <= 1'b0;
            col       <= 5'd0;
            vram_rd   <= 1'b1;
            vram_addr <= map_addr;
            row_full  <= 1'b0;
        end else begin
            case (state)
                ppu_pipe_pkg::map_rd: begin
                    half <= ~half;
                    if (half) begin
                        vram_addr <= tile_addr;
                        state     <= ppu_pipe_pkg::lo_rd;
                    end
                end
                ppu_pipe_pkg::lo_rd: begin
                    half <= ~half;
                    if (half) begin
                        row_lo    <= bg_on ? vram_data : 8'd0;
                        vram_addr <= vram_addr + 16'd1;   // high plane follows
                        state     <= ppu_pipe_pkg::hi_rd;
                    end
                end
                ppu_pipe_pkg::hi_rd: begin
                    half <= ~half;
                    if (half) begin
                        row_hi   <= bg_on ? vram_data : 8'd0;
                        vram_rd  <= 1'b0;
                        row_full <= 1'b1;
                        col      <= col + 5'd1;
                        state    <= ppu_pipe_pkg::full;
                    end
                end
                ppu_pipe_pkg::full: begin
                    if (row_take) begin
                        row_full <= 1'b0;
                        if (col == LINE_TILES) begin
                            state <= ppu_pipe_pkg::idle;  // line done
                        end else begin
                            state     <= ppu_pipe_pkg::map_rd;
                            vram_rd   <= 1'b1;
                            vram_addr <= map_addr;
                        end
                    end
                end
                default: ;  // idle until the next line_start
            endcase
        end
    end

endmodule

// ==== logic/lcd_timing.sv ====
// lcd_timing: dot and line counters, mode sequencer, LY/LYC compare, vblank pulse

`timescale 1ns/1ps

`include "ppu_params.svh"

module lcd_timing (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    lcd_on,
    input  logic [7:0]              lyc,
    input  logic                    px_done_line,
    output ppu_pipe_pkg::ppu_mode_e mode,
    output logic [7:0]              ly,
    output logic                    coincidence,
    output logic                    line_start,
    output logic                    irq_vblank
);

    logic [8:0] dot;
    logic       last_dot;
    logic [7:0] ly_next;

    assign last_dot = (dot == 9'(`LINE_DOTS - 1));
    assign ly_next  = (ly == 8'(`FRAME_LINES - 1)) ? 8'd0 : ly + 8'd1;

    assign coincidence = (ly == lyc);

    // a disabled display sits at the top of line 0 in scan mode
    always_ff @(posedge clk) begin
        if (rst || !lcd_on) begin
            dot        <= 9'd0;
            ly         <= 8'd0;
            mode       <= ppu_pipe_pkg::scan;
            line_start <= 1'b0;
            irq_vblank <= 1'b0;
        end else begin
            line_start <= 1'b0;
            irq_vblank <= 1'b0;
            if (last_dot) begin
                dot <= 9'd0;
                ly  <= ly_next;
                if (ly_next < 8'(`VISIBLE_LINES)) begin
                    mode <= ppu_pipe_pkg::scan;
                end else begin
                    mode <= ppu_pipe_pkg::v_blank;
                    // once per frame, on the first vblank line
                    irq_vblank <= (ly_next == 8'(`VISIBLE_LINES));
                end
            end else begin
                dot <= dot + 9'd1;
                if (mode == ppu_pipe_pkg::scan && dot == 9'(`SCAN_DOTS - 1)) begin
                    mode       <= ppu_pipe_pkg::draw;  // draw starts at dot 80
                    line_start <= 1'b1;
                end else if (mode == ppu_pipe_pkg::draw && px_done_line) begin
                    mode <= ppu_pipe_pkg::h_blank;
                end
            end
        end
    end

    a_dot_range: assert property (
        @(posedge clk) disable iff (rst) dot < 9'(`LINE_DOTS)
    );

    // draw has to finish inside the visible lines
    a_no_draw_in_vblank: assert property (
        @(posedge clk) disable iff (rst)
        !(mode == ppu_pipe_pkg::draw && ly >= 8'(`VISIBLE_LINES))
    );

endmodule

// ==== logic/lcd_reg_file.sv ====
// lcd_reg_file: CPU register writes and reads, STAT interrupt edge detector

`timescale 1ns/1ps

module lcd_reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [15:0]             addr,
    input  logic                    wr,
    input  logic                    rd,
    input  logic [7:0]              wr_data,
    input  ppu_pipe_pkg::ppu_mode_e mode,
    input  logic [7:0]              ly,
    input  logic                    coincidence,
    output logic [7:0]              rd_data,
    output lcd_reg_pkg::lcdc_t      lcdc,
    output logic [7:0]              scy,
    output logic [7:0]              scx,
    output logic [7:0]              lyc,
    output logic [7:0]              bgp,
    output lcd_reg_pkg::stat_en_t   stat_en,
    output logic                    irq_stat
);

    logic stat_cond;
    logic stat_cond_q;

    // register writes, LY is read only
    always_ff @(posedge clk) begin
        if (rst) begin
            lcdc    <= '0;
            scy     <= 8'd0;
            scx     <= 8'd0;
            lyc     <= 8'd0;
            bgp     <= 8'd0;
            stat_en <= '0;
        end else if (wr) begin
            case (addr)
                lcd_reg_pkg::reg_lcdc: lcdc    <= lcd_reg_pkg::lcdc_t'(wr_data);
                lcd_reg_pkg::reg_stat: stat_en <= lcd_reg_pkg::stat_en_t'(wr_data[6:3]);
                lcd_reg_pkg::reg_scy:  scy     <= wr_data;
                lcd_reg_pkg::reg_scx:  scx     <= wr_data;
                lcd_reg_pkg::reg_lyc:  lyc     <= wr_data;
                lcd_reg_pkg::reg_bgp:  bgp     <= wr_data;
                default: ;
            endcase
        end
    end

    // combinational read, unmapped addresses float high
    always_comb begin
        rd_data = 8'hFF;
        if (rd) begin
            case (addr)
                lcd_reg_pkg::reg_lcdc: rd_data = lcdc;
                lcd_reg_pkg::reg_stat: rd_data = {1'b1, stat_en, coincidence, mode};
                lcd_reg_pkg::reg_scy:  rd_data = scy;
                lcd_reg_pkg::reg_scx:  rd_data = scx;
                lcd_reg_pkg::reg_ly:   rd_data = ly;    // live line count
                lcd_reg_pkg::reg_lyc:  rd_data = lyc;
                lcd_reg_pkg::reg_bgp:  rd_data = bgp;
                default:               rd_data = 8'hFF;
            endcase
        end
    end

    // vblank also raises the request when scan_en is set
    assign stat_cond = lcdc.lcd_on &
                       ((stat_en.lyc_en & coincidence) |
                        (stat_en.hblank_en & (mode == ppu_pipe_pkg::h_blank)) |
                        (stat_en.scan_en & (mode == ppu_pipe_pkg::scan)) |
                        ((stat_en.vblank_en | stat_en.scan_en) &
                         (mode == ppu_pipe_pkg::v_blank)));

    always_ff @(posedge clk) begin
        if (rst) begin
            stat_cond_q <= 1'b0;
        end else begin
            stat_cond_q <= stat_cond;
        end
    end

    assign irq_stat = stat_cond & ~stat_cond_q;  // rising edge only

    // a held condition must not retrigger
    a_irq_stat_pulse: assert property (
        @(posedge clk) disable iff (rst) irq_stat |=> !irq_stat
    );

endmodule

// ==== logic/ppu_pipe_pkg.sv ====
// mode sequencer encoding, fetcher states and pixel shade type

package ppu_pipe_pkg;

    // encoding matches STAT bits 1:0
    typedef enum logic [1:0] {
        h_blank = 2'd0,
        v_blank = 2'd1,
        scan    = 2'd2,
        draw    = 2'd3
    } ppu_mode_e;

    // background fetcher, one map read and two row reads per tile
    typedef enum logic [2:0] {
        idle   = 3'd0,
        map_rd = 3'd1,
        lo_rd  = 3'd2,
        hi_rd  = 3'd3,
        full   = 3'd4   // row ready, waiting for the shifter
    } fetch_state_e;

    // color index or shade of one pixel
    typedef logic [1:0] shade_t;

endpackage

// ==== logic/lcd_reg_pkg.sv ====
// register address map, LCDC bit fields and STAT interrupt enables

package lcd_reg_pkg;

    // cpu visible register addresses
    typedef enum logic [15:0] {
        reg_lcdc = 16'hFF40,
        reg_stat = 16'hFF41,
        reg_scy  = 16'hFF42,
        reg_scx  = 16'hFF43,
        reg_ly   = 16'hFF44,
        reg_lyc  = 16'hFF45,
        reg_bgp  = 16'hFF47
    } reg_addr_e;

    // LCDC, bit 7 first
    typedef struct packed {
        logic lcd_on;
        logic win_map;   // no window in this unit
        logic win_on;
        logic tile_sel;  // 1: unsigned tiles at 8000h
        logic map_sel;   // 1: map at 9C00h
        logic obj_size;  // no sprites in this unit
        logic obj_on;
        logic bg_on;
    } lcdc_t;

    // STAT bits 6..3
    typedef struct packed {
        logic lyc_en;
        logic scan_en;
        logic vblank_en;
        logic hblank_en;
    } stat_en_t;

endpackage

// ==== include/ppu_params.svh ====
// display format, frame timing and VRAM base address macros

`ifndef PPU_PARAMS_SVH
`define PPU_PARAMS_SVH

// line timing in dots
`define LINE_DOTS 456
`define SCAN_DOTS 80

// frame timing in lines
`define VISIBLE_LINES 144
`define FRAME_LINES 154

// visible pixels per line
`define SCREEN_W 160

// background tile maps, 32x32 entries each
`define MAP0_BASE 16'h9800
`define MAP1_BASE 16'h9C00

// tile data, unsigned index from 8000h
`define TILE_BASE_LO 16'h8000
// tile data, signed index centered on 9000h
`define TILE_BASE_HI 16'h9000

`endif
